// File: logic/memPkg.sv
package memPkg;

    localparam int AddrWidth = 18;
    localparam int WordWidth = 32;
    localparam int ByteWidth = 8;

    // only the low half of the address space is backed by RAM
    localparam int RamAddrWidth = 17;
    localparam int RamDepth = 1 << RamAddrWidth;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [WordWidth-1:0] wordT;
    typedef logic [ByteWidth-1:0] byteT;

    // access length in bytes
    typedef logic [2:0] lenT;

    localparam lenT LenByte = 3'd1;
    localparam lenT LenHalf = 3'd2;
    localparam lenT LenWord = 3'd4;

endpackage

// File: logic/cachePkg.sv
package cachePkg;

    // top quarter of the address space is I/O
    localparam logic [1:0] IoRegionSel = 2'b11;

    // one word per line
    localparam int OffsetBits = 2;

    function automatic int indexBits(input int lines);
        return $clog2(lines);
    endfunction

    function automatic int tagBits(input int lines);
        return memPkg::AddrWidth - OffsetBits - $clog2(lines);
    endfunction

    function automatic logic isCacheable(input memPkg::addrT addr);
        return addr[memPkg::AddrWidth-1 -: 2] != IoRegionSel;
    endfunction

endpackage

// File: logic/instCache.sv
`timescale 1ns/1ps

module instCache #(
    parameter int CacheLines = 128
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         fetchEn,
    input  memPkg::addrT fetchAddr,
    output logic         hit,
    output memPkg::wordT foundInst,
    output logic         memFetchEn,
    output memPkg::addrT memFetchAddr,
    input  logic         fillEn,
    input  memPkg::addrT fillAddr,
    input  memPkg::wordT fillData
);

    localparam int IndexBits = cachePkg::indexBits(CacheLines);
    localparam int TagBits = cachePkg::tagBits(CacheLines);
    localparam int TagLsb = cachePkg::OffsetBits + IndexBits;

    typedef logic [IndexBits-1:0] indexT;
    typedef logic [TagBits-1:0] tagT;

    memPkg::wordT dataMem [CacheLines];
    tagT tagMem [CacheLines];
    logic [CacheLines-1:0] lineValid;

    indexT lookupIdx;
    tagT lookupTag;
    indexT fillIdx;
    tagT fillTag;
    logic fillStore;

    assign lookupIdx = fetchAddr[cachePkg::OffsetBits +: IndexBits];
    assign lookupTag = fetchAddr[TagLsb +: TagBits];
    assign fillIdx = fillAddr[cachePkg::OffsetBits +: IndexBits];
    assign fillTag = fillAddr[TagLsb +: TagBits];

    // I/O words pass through to the core but never land in a line
    assign fillStore = fillEn && cachePkg::isCacheable(fillAddr);

    assign hit = fetchEn && lineValid[lookupIdx] && (tagMem[lookupIdx] == lookupTag);
    assign foundInst = dataMem[lookupIdx];

    // miss goes straight on to the arbiter
    assign memFetchEn = fetchEn && !hit;
    assign memFetchAddr = fetchAddr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lineValid <= '0;
        end else if (fillStore) begin
            lineValid[fillIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fillStore) begin
            dataMem[fillIdx] <= fillData;
            tagMem[fillIdx] <= fillTag;
        end
    end

endmodule

// File: logic/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic         clk,
    input  logic         rst,
    // instruction port
    input  logic         fetchEn,
    input  memPkg::addrT fetchAddr,
    input  logic         misTaken,
    output logic         instOutEn,
    output memPkg::wordT inst,
    output memPkg::addrT instAddr,
    // load/store port
    input  logic         lsEn,
    input  logic         lsWrite,
    input  memPkg::addrT lsAddr,
    input  memPkg::lenT  lsLen,
    input  memPkg::wordT storeData,
    output logic         lsDone,
    output memPkg::wordT loadData,
    // RAM side
    output logic         ramWrite,
    output memPkg::addrT ramAddr,
    output memPkg::byteT ramWriteData,
    input  memPkg::byteT ramReadData
);

    typedef enum logic [2:0] {
        SrcNone,
        SrcWaitLs,
        SrcWaitFetch,
        SrcNewLs,
        SrcNewFetch
    } srcT;

    // control
    logic busy;
    logic servingLs;
    logic runWrite;
    memPkg::lenT stage;
    logic waitLs;
    logic waitFetch;

    // running access
    memPkg::addrT runAddr;
    memPkg::lenT runLen;
    memPkg::wordT runData;

    // waiting slots
    memPkg::addrT waitLsAddr;
    memPkg::lenT waitLsLen;
    logic waitLsWrite;
    memPkg::wordT waitLsData;
    memPkg::addrT waitFetchAddr;

    logic lastStage;
    logic cancelRun;
    logic canStart;
    logic sameAsInFlight;
    logic fetchOk;
    logic [1:0] rdIdx;
    srcT startSel;

    memPkg::addrT startAddr;
    memPkg::lenT startLen;
    logic startWrite;
    memPkg::wordT startData;
    logic startIsLs;

    assign lastStage = busy && (stage == runLen);
    assign cancelRun = busy && !servingLs && misTaken;
    assign canStart = !busy || lastStage || cancelRun;

    // the core keeps fetchEn up until it sees the answer
    assign sameAsInFlight = ((busy && !servingLs) || instOutEn) && (fetchAddr == instAddr);
    assign fetchOk = fetchEn && !misTaken && !sameAsInFlight;

    // stage 4 wraps to index 3
    assign rdIdx = stage[1:0] - 2'd1;

    assign ramAddr = runAddr;
    assign ramWrite = busy && runWrite && (stage != runLen);
    assign ramWriteData = runData[{stage[1:0], 3'b000} +: 8];

    // waiting entries before new ones, load/store before fetch
    always_comb begin
        startSel = SrcNone;
        if (canStart) begin
            if (waitLs) begin
                startSel = SrcWaitLs;
            end else if (waitFetch && !misTaken) begin
                startSel = SrcWaitFetch;
            end else if (lsEn) begin
                startSel = SrcNewLs;
            end else if (fetchOk) begin
                startSel = SrcNewFetch;
            end
        end
    end

    always_comb begin
        startAddr = fetchAddr;
        startLen = memPkg::LenWord;
        startWrite = 1'b0;
        startData = '0;
        startIsLs = 1'b0;
        case (startSel)
            SrcWaitLs: begin
                startAddr = waitLsAddr;
                startLen = waitLsLen;
                startWrite = waitLsWrite;
                startData = waitLsData;
                startIsLs = 1'b1;
            end
            SrcWaitFetch: begin
                startAddr = waitFetchAddr;
            end
            SrcNewLs: begin
                startAddr = lsAddr;
                startLen = lsLen;
                startWrite = lsWrite;
                startData = storeData;
                startIsLs = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            servingLs <= 1'b0;
            runWrite <= 1'b0;
            stage <= '0;
            waitLs <= 1'b0;
            waitFetch <= 1'b0;
            instOutEn <= 1'b0;
            lsDone <= 1'b0;
        end else begin
            instOutEn <= lastStage && !servingLs && !misTaken;
            lsDone <= lastStage && servingLs;

            if (startSel != SrcNone) begin
                busy <= 1'b1;
                stage <= '0;
                servingLs <= startIsLs;
                runWrite <= startWrite;
            end else if (lastStage || cancelRun) begin
                busy <= 1'b0;
                stage <= '0;
                runWrite <= 1'b0;
            end else if (busy) begin
                stage <= stage + 3'd1;
            end

            if (startSel == SrcWaitLs) begin
                waitLs <= 1'b0;
            end
            if (lsEn && startSel != SrcNewLs) begin
                waitLs <= 1'b1;
            end

            // a held fetch must not be queued again once it starts
            if (fetchOk && startSel != SrcNewFetch) begin
                waitFetch <= 1'b1;
            end
            if (misTaken || startSel == SrcWaitFetch) begin
                waitFetch <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lsEn && startSel != SrcNewLs) begin
            waitLsAddr <= lsAddr;
            waitLsLen <= lsLen;
            waitLsWrite <= lsWrite;
            waitLsData <= storeData;
        end
        if (fetchOk && startSel != SrcNewFetch) begin
            waitFetchAddr <= fetchAddr;
        end

        // byte from the previous address is on ramReadData now
        if (busy && !runWrite && stage != '0) begin
            if (servingLs) begin
                loadData[{rdIdx, 3'b000} +: 8] <= ramReadData;
            end else begin
                inst[{rdIdx, 3'b000} +: 8] <= ramReadData;
            end
        end

        if (startSel != SrcNone) begin
            runAddr <= startAddr;
            runLen <= startLen;
            runData <= startData;
            if (startIsLs && !startWrite) begin
                loadData <= '0;
            end
            if (!startIsLs) begin
                instAddr <= startAddr;
            end
        end else if (busy) begin
            runAddr <= runAddr + 1'b1;
        end
    end

endmodule

// File: logic/byteRam.sv
`timescale 1ns/1ps

module byteRam (
    input  logic         clk,
    input  logic         write,
    input  memPkg::addrT addr,
    input  memPkg::byteT writeData,
    output memPkg::byteT readData
);

    memPkg::byteT mem [memPkg::RamDepth];

    logic [memPkg::RamAddrWidth-1:0] ramIdx;

    // upper address bit is dropped, I/O aliases onto the upper half
    assign ramIdx = addr[memPkg::RamAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[ramIdx] <= writeData;
        end
        readData <= mem[ramIdx];
    end

endmodule

// File: logic/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem #(
    parameter int CacheLines = 128
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         fetchEn,
    input  memPkg::addrT fetchAddr,
    output logic         hit,
    output memPkg::wordT foundInst,
    output logic         instOutEn,
    output memPkg::wordT inst,
    input  logic         misTaken,
    input  logic         lsEn,
    input  logic         lsWrite,
    input  memPkg::addrT lsAddr,
    input  memPkg::lenT  lsLen,
    input  memPkg::wordT storeData,
    output logic         lsDone,
    output memPkg::wordT loadData
);

    logic memFetchEn;
    memPkg::addrT memFetchAddr;
    memPkg::addrT instAddr;
    logic ramWrite;
    memPkg::addrT ramAddr;
    memPkg::byteT ramWriteData;
    memPkg::byteT ramReadData;

    instCache #(
        .CacheLines(CacheLines)
    ) i_instCache (
        .clk         (clk),
        .rst         (rst),
        .fetchEn     (fetchEn),
        .fetchAddr   (fetchAddr),
        .hit         (hit),
        .foundInst   (foundInst),
        .memFetchEn  (memFetchEn),
        .memFetchAddr(memFetchAddr),
        .fillEn      (instOutEn),
        .fillAddr    (instAddr),
        .fillData    (inst)
    );

    memArbiter i_memArbiter (
        .clk         (clk),
        .rst         (rst),
        .fetchEn     (memFetchEn),
        .fetchAddr   (memFetchAddr),
        .misTaken    (misTaken),
        .instOutEn   (instOutEn),
        .inst        (inst),
        .instAddr    (instAddr),
        .lsEn        (lsEn),
        .lsWrite     (lsWrite),
        .lsAddr      (lsAddr),
        .lsLen       (lsLen),
        .storeData   (storeData),
        .lsDone      (lsDone),
        .loadData    (loadData),
        .ramWrite    (ramWrite),
        .ramAddr     (ramAddr),
        .ramWriteData(ramWriteData),
        .ramReadData (ramReadData)
    );

    byteRam i_byteRam (
        .clk      (clk),
        .write    (ramWrite),
        .addr     (ramAddr),
        .writeData(ramWriteData),
        .readData (ramReadData)
    );

endmodule

// File: include/memCompare.svh
`ifndef MEM_COMPARE_SVH
`define MEM_COMPARE_SVH

// X or Z on the DUT side counts as a mismatch
task automatic compareWord(
    input string name,
    input memPkg::wordT expected,
    input memPkg::wordT actual,
    inout int errors
);
    if (actual !== expected) begin
        $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        errors++;
    end
endtask

task automatic compareFlag(
    input string name,
    input logic expected,
    input logic actual,
    inout int errors
);
    if (actual !== expected) begin
        $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
        errors++;
    end
endtask

`endif

// File: testbench/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;

    localparam int CacheLines = 128;
    localparam int IndexBits = $clog2(CacheLines);
    localparam int NumLs = 12;
    localparam int NumFetch = 4;
    localparam int NumIo = 3;
    localparam int NumAccesses = 2 * NumLs + 3 * NumFetch + 3 * NumIo + 7;
    localparam int CycleLimit = 6 * NumAccesses + 200;

    logic clk;
    logic rst;
    logic fetchEn;
    memPkg::addrT fetchAddr;
    logic hit;
    memPkg::wordT foundInst;
    logic instOutEn;
    memPkg::wordT inst;
    logic misTaken;
    logic lsEn;
    logic lsWrite;
    memPkg::addrT lsAddr;
    memPkg::lenT lsLen;
    memPkg::wordT storeData;
    logic lsDone;
    memPkg::wordT loadData;

    int seed = 20730;
    int errors = 0;
    int testCount = 0;
    int cycleCount = 0;

    // shadow of the RAM, indexed like byteRam
    memPkg::byteT shadow [memPkg::RamDepth];
    logic [CacheLines-1:0] refValid = '0;
    memPkg::addrT refLineAddr [CacheLines];

    // one entry per load/store in flight
    logic expWrites [$];
    memPkg::wordT expLoads [$];

    `include "memCompare.svh"

    memSubsystem #(
        .CacheLines(CacheLines)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .fetchEn  (fetchEn),
        .fetchAddr(fetchAddr),
        .hit      (hit),
        .foundInst(foundInst),
        .instOutEn(instOutEn),
        .inst     (inst),
        .misTaken (misTaken),
        .lsEn     (lsEn),
        .lsWrite  (lsWrite),
        .lsAddr   (lsAddr),
        .lsLen    (lsLen),
        .storeData(storeData),
        .lsDone   (lsDone),
        .loadData (loadData)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // little-endian, zero above len bytes
    function automatic memPkg::wordT refRead(input memPkg::addrT addr, input memPkg::lenT len);
        memPkg::wordT word;
        memPkg::addrT a;
        word = '0;
        for (int i = 0; i < len; i++) begin
            a = addr + i;
            word[8*i +: 8] = shadow[a[memPkg::RamAddrWidth-1:0]];
        end
        return word;
    endfunction

    function automatic logic refHit(input memPkg::addrT addr);
        int idx;
        idx = addr[2 +: IndexBits];
        return cachePkg::isCacheable(addr) && refValid[idx] && (refLineAddr[idx] == addr);
    endfunction

    // distinct slots keep addresses apart within a test
    function automatic memPkg::addrT randWordAddr(input logic [3:0] region, input logic [3:0] slot);
        logic [31:0] r;
        r = $random(seed);
        return {region, r[13:6], slot, 2'b00};
    endfunction

    task automatic writeShadow(input memPkg::addrT addr, input memPkg::lenT len,
                               input memPkg::wordT data);
        memPkg::addrT a;
        for (int i = 0; i < len; i++) begin
            a = addr + i;
            shadow[a[memPkg::RamAddrWidth-1:0]] = data[8*i +: 8];
        end
    endtask

    task automatic startLs(input logic write, input memPkg::addrT addr, input memPkg::lenT len,
                           input memPkg::wordT data);
        if (write) begin
            writeShadow(addr, len, data);
        end else begin
            expLoads.push_back(refRead(addr, len));
        end
        expWrites.push_back(write);
        lsEn = 1'b1;
        lsWrite = write;
        lsAddr = addr;
        lsLen = len;
        storeData = data;
    endtask

    // issue on an idle arbiter and check the done latency
    task automatic runLs(input logic write, input memPkg::addrT addr, input memPkg::lenT len,
                         input memPkg::wordT data);
        int cycles;
        startLs(write, addr, len, data);
        @(posedge clk);
        #1;
        lsEn = 1'b0;
        cycles = 0;
        while (!lsDone) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        if (cycles != len + 1) begin
            $display("%0t lsDone came %0d cycles after the request, expected %0d",
                     $time, cycles, len + 1);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic runFetch(input memPkg::addrT addr, output logic wasHit);
        fetchEn = 1'b1;
        fetchAddr = addr;
        do begin
            @(negedge clk);
        end while (!hit && !instOutEn);
        wasHit = hit;
        @(posedge clk);
        #1;
        fetchEn = 1'b0;
    endtask

    task automatic reportTest(input string name, input int errsBefore);
        testCount++;
        if (errors == errsBefore) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            $display("test %0d %s: %0d errors", testCount, name, errors - errsBefore);
        end
    endtask

    // scoreboard, sampled mid-cycle
    always @(negedge clk) begin
        logic wasWrite;
        int idx;
        if (!rst) begin
            if (fetchEn) begin
                compareFlag("hit", refHit(fetchAddr), hit, errors);
                if (hit) begin
                    compareWord("foundInst", refRead(fetchAddr, memPkg::LenWord), foundInst,
                                errors);
                end
            end
            if (instOutEn) begin
                if (!fetchEn) begin
                    $display("%0t instOutEn pulsed with no fetch waiting", $time);
                    errors++;
                end else begin
                    compareWord("inst", refRead(fetchAddr, memPkg::LenWord), inst, errors);
                    if (cachePkg::isCacheable(fetchAddr)) begin
                        idx = fetchAddr[2 +: IndexBits];
                        refValid[idx] = 1'b1;
                        refLineAddr[idx] = fetchAddr;
                    end
                end
            end
            if (lsDone) begin
                if (expWrites.size() == 0) begin
                    $display("%0t lsDone pulsed with no access outstanding", $time);
                    errors++;
                end else begin
                    wasWrite = expWrites.pop_front();
                    if (!wasWrite) begin
                        compareWord("loadData", expLoads.pop_front(), loadData, errors);
                    end
                end
            end
        end
    end

    initial begin
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout, run still going after %0d cycles", cycleCount);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        memPkg::addrT addr;
        memPkg::addrT lsTarget;
        memPkg::lenT len;
        memPkg::addrT lsAddrs [NumLs];
        memPkg::lenT lsLens [NumLs];
        logic wasHit;
        int errsBefore;
        int doneCount;

        rst = 1'b1;
        fetchEn = 1'b0;
        fetchAddr = '0;
        misTaken = 1'b0;
        lsEn = 1'b0;
        lsWrite = 1'b0;
        lsAddr = '0;
        lsLen = memPkg::LenWord;
        storeData = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        errsBefore = errors;
        for (int i = 0; i < NumLs; i++) begin
            addr = $random(seed);
            addr[17:15] = '0;
            case ($unsigned($random(seed)) % 3)
                0: len = memPkg::LenByte;
                1: len = memPkg::LenHalf;
                default: len = memPkg::LenWord;
            endcase
            lsAddrs[i] = addr;
            lsLens[i] = len;
            runLs(1'b1, addr, len, $random(seed));
        end
        for (int i = 0; i < NumLs; i++) begin
            runLs(1'b0, lsAddrs[i], lsLens[i], '0);
        end
        reportTest("store and load", errsBefore);

        errsBefore = errors;
        for (int i = 0; i < NumFetch; i++) begin
            addr = randWordAddr(4'b0010, 4'(i));
            runLs(1'b1, addr, memPkg::LenWord, $random(seed));
            runFetch(addr, wasHit);
            compareFlag("hit", 1'b0, wasHit, errors);
            runFetch(addr, wasHit);
            compareFlag("hit", 1'b1, wasHit, errors);
        end
        reportTest("cacheable fetch", errsBefore);

        errsBefore = errors;
        for (int i = 0; i < NumIo; i++) begin
            addr = randWordAddr(4'b1100, 4'(i));
            runLs(1'b1, addr, memPkg::LenWord, $random(seed));
            repeat (2) begin
                runFetch(addr, wasHit);
                compareFlag("hit", 1'b0, wasHit, errors);
            end
        end
        reportTest("io fetch", errsBefore);

        // store keeps the arbiter busy, then fetch and load arrive together
        errsBefore = errors;
        addr = randWordAddr(4'b1000, 4'd0);
        lsTarget = randWordAddr(4'b0110, 4'd0);
        runLs(1'b1, addr, memPkg::LenWord, $random(seed));
        startLs(1'b1, lsTarget, memPkg::LenWord, $random(seed));
        @(posedge clk);
        #1;
        lsEn = 1'b0;
        @(posedge clk);
        #1;
        fetchEn = 1'b1;
        fetchAddr = addr;
        startLs(1'b0, lsTarget, memPkg::LenHalf, '0);
        @(posedge clk);
        #1;
        lsEn = 1'b0;
        doneCount = 0;
        do begin
            @(negedge clk);
            if (lsDone) begin
                doneCount++;
            end
        end while (!instOutEn);
        if (doneCount != 2) begin
            $display("%0t instOutEn came after %0d of 2 lsDone pulses", $time, doneCount);
            errors++;
        end
        @(posedge clk);
        #1;
        fetchEn = 1'b0;
        reportTest("contention", errsBefore);

        errsBefore = errors;
        addr = randWordAddr(4'b1001, 4'd0);
        runLs(1'b1, addr, memPkg::LenWord, $random(seed));
        fetchEn = 1'b1;
        fetchAddr = addr;
        // accepted at the first edge, two stages in when cancelled
        repeat (3) @(posedge clk);
        #1;
        misTaken = 1'b1;
        fetchEn = 1'b0;
        @(posedge clk);
        #1;
        misTaken = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        runFetch(addr, wasHit);
        compareFlag("hit", 1'b0, wasHit, errors);
        reportTest("cancel", errsBefore);

        $display("%0d tests run, %0d errors", testCount, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
logic/memPkg.sv
logic/cachePkg.sv
logic/instCache.sv
logic/memArbiter.sv
logic/byteRam.sv
logic/memSubsystem.sv
testbench/memSubsystemTb.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - logic/memPkg.sv
  - logic/cachePkg.sv
  - logic/instCache.sv
  - logic/memArbiter.sv
  - logic/byteRam.sv
  - logic/memSubsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/memSubsystemTb.sv
